// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bflyNetTb
FILELIST = vlog.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hdl/bflyNet.sv ====
// Top level of the radix-2 butterfly network, tagging requests and chaining the stages
`timescale 1ns/1ns

module bflyNet
  import bflyPkg::*;
#(
  parameter int unsigned NumPorts  = DefNumPorts,
  parameter int unsigned DataWidth = DefDataWidth
) (
  input  logic                                        clk_i,
  input  logic                                        rstN_i,
  // Initiator side
  input  logic [NumPorts-1:0]                         valid_i,
  output logic [NumPorts-1:0]                         ready_o,
  input  logic [NumPorts-1:0][$clog2(NumPorts)-1:0]   tgtAddr_i,
  input  logic [NumPorts-1:0][DataWidth-1:0]          data_i,
  // Target side
  output logic [NumPorts-1:0]                         valid_o,
  input  logic [NumPorts-1:0]                         ready_i,
  output logic [NumPorts-1:0][$clog2(NumPorts)-1:0]   iniAddr_o,
  output logic [NumPorts-1:0][DataWidth-1:0]          data_o
);

  localparam int unsigned AddrWidth = $clog2(NumPorts);
  localparam int unsigned NumStages = AddrWidth;

  // Index l is the input of stage l, index NumStages the network output
  logic [NumStages:0][NumPorts-1:0]                stValid;
  logic [NumStages:0][NumPorts-1:0]                stReady;
  logic [NumStages:0][NumPorts-1:0][AddrWidth-1:0] stTgtAddr;
  logic [NumStages:0][NumPorts-1:0][AddrWidth-1:0] stIniAddr;
  logic [NumStages:0][NumPorts-1:0][DataWidth-1:0] stData;

  assign stValid[0]   = valid_i;
  assign ready_o      = stReady[0];
  assign stTgtAddr[0] = tgtAddr_i;
  assign stData[0]    = data_i;

  // Each request carries the number of the port it came in on
  for (genvar p = 0; p < NumPorts; p++) begin : genIniTag
    assign stIniAddr[0][p] = AddrWidth'(p);
  end

  for (genvar l = 0; l < NumStages; l++) begin : genStage
    bflyStage #(
      .NumPorts (NumPorts),
      .DataWidth(DataWidth),
      .StageIdx (l)
    ) bflyStage_inst (
      .clk_i    (clk_i),
      .rstN_i   (rstN_i),
      .valid_i  (stValid[l]),
      .ready_o  (stReady[l]),
      .tgtAddr_i(stTgtAddr[l]),
      .iniAddr_i(stIniAddr[l]),
      .data_i   (stData[l]),
      .valid_o  (stValid[l+1]),
      .ready_i  (stReady[l+1]),
      .tgtAddr_o(stTgtAddr[l+1]),
      .iniAddr_o(stIniAddr[l+1]),
      .data_o   (stData[l+1])
    );
  end

  // Target address is fully consumed by the last stage
  assign valid_o              = stValid[NumStages];
  assign stReady[NumStages]   = ready_i;
  assign iniAddr_o            = stIniAddr[NumStages];
  assign data_o               = stData[NumStages];

  if ((NumPorts < 2) || ((1 << $clog2(NumPorts)) != NumPorts)) begin : genParamCheck
    $fatal(1, "bflyNet: NumPorts is %0d but must be a power of two and at least 2", NumPorts);
  end

endmodule : bflyNet

// ==== hdl/bflyPkg.sv ====
// Shared sizes and types of the butterfly network, imported by its modules and the testbench
package bflyPkg;

  // Default number of initiators and of targets
  // Must be a power of two and at least 2, since each stage steers on one address bit
  localparam int unsigned DefNumPorts = 8;

  // Default width of the request data word
  localparam int unsigned DefDataWidth = 16;

  // Round-robin state of a 2x2 switch
  // Names the input that wins the next tie for an output slot
  typedef enum logic {
    PrioUpper = 1'b0,
    PrioLower = 1'b1
  } prioT;

endpackage : bflyPkg

// ==== hdl/bflyStage.sv ====
// One layer of 2x2 switches with the butterfly shuffle that feeds the next layer
`timescale 1ns/1ns

module bflyStage
  import bflyPkg::*;
#(
  parameter int unsigned NumPorts  = DefNumPorts,
  parameter int unsigned DataWidth = DefDataWidth,
  parameter int unsigned StageIdx  = 0
) (
  input  logic                                        clk_i,
  input  logic                                        rstN_i,
  input  logic [NumPorts-1:0]                         valid_i,
  output logic [NumPorts-1:0]                         ready_o,
  input  logic [NumPorts-1:0][$clog2(NumPorts)-1:0]   tgtAddr_i,
  input  logic [NumPorts-1:0][$clog2(NumPorts)-1:0]   iniAddr_i,
  input  logic [NumPorts-1:0][DataWidth-1:0]          data_i,
  output logic [NumPorts-1:0]                         valid_o,
  input  logic [NumPorts-1:0]                         ready_i,
  output logic [NumPorts-1:0][$clog2(NumPorts)-1:0]   tgtAddr_o,
  output logic [NumPorts-1:0][$clog2(NumPorts)-1:0]   iniAddr_o,
  output logic [NumPorts-1:0][DataWidth-1:0]          data_o
);

  localparam int unsigned AddrWidth   = $clog2(NumPorts);
  localparam int unsigned NumStages   = AddrWidth;
  localparam int unsigned NumSwitches = NumPorts / 2;

  logic [NumSwitches-1:0][1:0]                swValid;
  logic [NumSwitches-1:0][1:0]                swReady;
  logic [NumSwitches-1:0][1:0][AddrWidth-1:0] swTgtAddr;
  logic [NumSwitches-1:0][1:0][AddrWidth-1:0] swIniAddr;
  logic [NumSwitches-1:0][1:0][DataWidth-1:0] swData;
  logic                                       seenIn;

  // Lanes 2r and 2r+1 enter switch r
  for (genvar r = 0; r < NumSwitches; r++) begin : genSwitch
    bflySwitch #(
      .NumPorts (NumPorts),
      .DataWidth(DataWidth)
    ) bflySwitch_inst (
      .clk_i    (clk_i),
      .rstN_i   (rstN_i),
      .valid_i  (valid_i[2*r +: 2]),
      .ready_o  (ready_o[2*r +: 2]),
      .tgtAddr_i(tgtAddr_i[2*r +: 2]),
      .iniAddr_i(iniAddr_i[2*r +: 2]),
      .data_i   (data_i[2*r +: 2]),
      .valid_o  (swValid[r]),
      .ready_i  (swReady[r]),
      .tgtAddr_o(swTgtAddr[r]),
      .iniAddr_o(swIniAddr[r]),
      .data_o   (swData[r])
    );
  end

  if (StageIdx < NumStages - 1) begin : genShuffle
    // Block size of the butterfly permutation for this layer
    localparam int unsigned Pow = 2 ** (NumStages - StageIdx - 2);

    for (genvar r = 0; r < NumSwitches; r++) begin : genRow
      for (genvar s = 0; s < 2; s++) begin : genPort
        localparam int unsigned K = Pow * s + (r % Pow) + (r / Pow / 2) * Pow * 2;
        localparam int unsigned J = (r / Pow) % 2;

        assign valid_o[2*K+J]   = swValid[r][s];
        assign tgtAddr_o[2*K+J] = swTgtAddr[r][s];
        assign iniAddr_o[2*K+J] = swIniAddr[r][s];
        assign data_o[2*K+J]    = swData[r][s];
        // Ready comes back through the inverse mapping
        assign swReady[r][s]    = ready_i[2*K+J];
      end
    end
  end else begin : genDirect
    // Last layer faces the targets directly
    for (genvar r = 0; r < NumSwitches; r++) begin : genRow
      for (genvar s = 0; s < 2; s++) begin : genPort
        assign valid_o[2*r+s]   = swValid[r][s];
        assign tgtAddr_o[2*r+s] = swTgtAddr[r][s];
        assign iniAddr_o[2*r+s] = swIniAddr[r][s];
        assign data_o[2*r+s]    = swData[r][s];
        assign swReady[r][s]    = ready_i[2*r+s];
      end
    end
  end

  // Sticky flag once any request has entered this layer
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      seenIn <= 1'b0;
    end else if (|(valid_i & ready_o)) begin
      seenIn <= 1'b1;
    end
  end

  // No output request can appear out of nowhere
  assert property (@(posedge clk_i) disable iff (!rstN_i) (|valid_o) |-> seenIn)
  else $error("bflyStage: stage %0d shows valid before any input", StageIdx);

endmodule : bflyStage

// ==== hdl/bflySwitch.sv ====
// Two-by-two routing switch of the butterfly network, steering on the top target-address bit
`timescale 1ns/1ns

module bflySwitch
  import bflyPkg::*;
#(
  parameter int unsigned NumPorts  = DefNumPorts,
  parameter int unsigned DataWidth = DefDataWidth
) (
  input  logic                                   clk_i,
  input  logic                                   rstN_i,
  // Initiator side
  input  logic [1:0]                             valid_i,
  output logic [1:0]                             ready_o,
  input  logic [1:0][$clog2(NumPorts)-1:0]       tgtAddr_i,
  input  logic [1:0][$clog2(NumPorts)-1:0]       iniAddr_i,
  input  logic [1:0][DataWidth-1:0]              data_i,
  // Target side
  output logic [1:0]                             valid_o,
  input  logic [1:0]                             ready_i,
  output logic [1:0][$clog2(NumPorts)-1:0]       tgtAddr_o,
  output logic [1:0][$clog2(NumPorts)-1:0]       iniAddr_o,
  output logic [1:0][DataWidth-1:0]              data_o
);

  localparam int unsigned AddrWidth = $clog2(NumPorts);

  logic [1:0] dest;
  logic [1:0] canAccept;
  logic [1:0] grant;
  logic [1:0] load;
  logic [1:0] src;
  logic       contested;
  logic       winner;
  prioT       prio;
  logic [1:0] slotValid;

  // Destination output of each input
  assign dest[0] = tgtAddr_i[0][AddrWidth-1];
  assign dest[1] = tgtAddr_i[1][AddrWidth-1];

  // A slot takes a new request when empty or drained this cycle
  assign canAccept = ~slotValid | ready_i;

  // Both inputs fight for the same output
  assign contested = valid_i[0] && valid_i[1] && (dest[0] == dest[1]);
  assign winner    = (prio == PrioUpper) ? 1'b0 : 1'b1;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      grant[k] = valid_i[k] && canAccept[dest[k]] && (!contested || (winner == 1'(k)));
    end
  end

  assign ready_o = grant;

  // Per output: whether a request is loaded and from which input
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      src[o]  = grant[1] && (dest[1] == 1'(o));
      load[o] = (grant[0] && (dest[0] == 1'(o))) || src[o];
    end
  end

  // Flip the priority only after a tie that was actually granted
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      prio <= PrioUpper;
    end else if (contested && canAccept[dest[0]]) begin
      prio <= (prio == PrioUpper) ? PrioLower : PrioUpper;
    end
  end

  // Slot occupancy
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      slotValid <= 2'b00;
    end else begin
      for (int o = 0; o < 2; o++) begin
        if (load[o]) begin
          slotValid[o] <= 1'b1;
        end else if (ready_i[o]) begin
          slotValid[o] <= 1'b0;
        end
      end
    end
  end

  // Slot payload, address moves up one bit for the next stage
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < 2; o++) begin
      if (load[o]) begin
        tgtAddr_o[o] <= tgtAddr_i[src[o]] << 1;
        iniAddr_o[o] <= iniAddr_i[src[o]];
        data_o[o]    <= data_i[src[o]];
      end
    end
  end

  assign valid_o = slotValid;

  // A stalled output keeps its request unchanged
  for (genvar o = 0; o < 2; o++) begin : genStableChk
    assert property (@(posedge clk_i) disable iff (!rstN_i)
      valid_o[o] && !ready_i[o] |=>
        valid_o[o] && $stable(tgtAddr_o[o]) && $stable(iniAddr_o[o]) && $stable(data_o[o]))
    else $error("bflySwitch: output %0d changed while stalled", o);
  end

  // Only one input may be granted into a slot per cycle
  assert property (@(posedge clk_i) disable iff (!rstN_i)
    !(grant[0] && grant[1] && (dest[0] == dest[1])))
  else $error("bflySwitch: both inputs granted to output %0d", dest[0]);

endmodule : bflySwitch

// ==== tests/bflyNetTb.sv ====
// Self-checking testbench for the butterfly network, run as the simulation top with the RTL list
`timescale 1ns/1ns

module bflyNetTb
  import bflyPkg::*;
();

  localparam int unsigned NumPorts      = DefNumPorts;
  localparam int unsigned DataWidth     = DefDataWidth;
  localparam int unsigned AddrWidth     = $clog2(NumPorts);
  localparam int          NumStages     = AddrWidth;
  localparam int          ResetCycles   = 16;
  localparam int          StallCycles   = 24;
  localparam int          RandomCycles  = 2000;
  localparam int          HotTarget     = 5;
  localparam int          StallTarget   = 2;
  localparam int          StimCycles    = ResetCycles + NumPorts * NumPorts * (NumStages + 4)
                                          + 16 * NumPorts + StallCycles + RandomCycles;
  localparam int          TimeoutCycles = StimCycles * 4 + 200;

  logic                                      clk_i     = 1'b0;
  logic                                      rstN_i    = 1'b0;
  logic [NumPorts-1:0]                       valid_i   = '0;
  logic [NumPorts-1:0]                       ready_o;
  logic [NumPorts-1:0][AddrWidth-1:0]        tgtAddr_i = '0;
  logic [NumPorts-1:0][DataWidth-1:0]        data_i    = '0;
  logic [NumPorts-1:0]                       valid_o;
  logic [NumPorts-1:0]                       ready_i   = '1;
  logic [NumPorts-1:0][AddrWidth-1:0]        iniAddr_o;
  logic [NumPorts-1:0][DataWidth-1:0]        data_o;

  // Pending stimulus per initiator and expected arrivals per target and initiator
  logic [AddrWidth-1:0]                      todoAddr [NumPorts][$];
  logic [DataWidth-1:0]                      todoData [NumPorts][$];
  logic [DataWidth-1:0]                      expData  [NumPorts][NumPorts][$];
  int                                        expCycle [NumPorts][NumPorts][$];

  logic [NumPorts-1:0]                       readyHold   = '1;
  logic                                      randomMode  = 1'b0;
  logic                                      latencyMode = 1'b0;
  string                                     testName    = "reset";
  int                                        cycleCnt    = 0;
  int                                        sentCnt     = 0;
  int                                        recvCnt     = 0;
  int                                        valueErrors    = 0;
  int                                        protocolErrors = 0;
  int                                        testErrors     = 0;
  logic [NumPorts-1:0]                       stalled = '0;
  logic [NumPorts-1:0][AddrWidth-1:0]        heldIni;
  logic [NumPorts-1:0][DataWidth-1:0]        heldData;

  bflyNet #(
    .NumPorts (NumPorts),
    .DataWidth(DataWidth)
  ) bflyNet_inst (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .tgtAddr_i(tgtAddr_i),
    .data_i   (data_i),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .iniAddr_o(iniAddr_o),
    .data_o   (data_o)
  );

  always #20 clk_i = ~clk_i;

  // A request always ends up at the port its address names
  function automatic int expectedTarget(input logic [AddrWidth-1:0] addr);
    return int'(addr);
  endfunction

  // Sender index in the top bits with a random payload below
  function automatic logic [DataWidth-1:0] makeData(input int ini);
    return {AddrWidth'(ini), (DataWidth-AddrWidth)'($urandom)};
  endfunction

  task automatic enqueueRequest(input int ini, input int tgt);
    todoAddr[ini].push_back(AddrWidth'(tgt));
    todoData[ini].push_back(makeData(ini));
  endtask

  task automatic checkValid(input string what, input logic [NumPorts-1:0] expVal,
                            input logic [NumPorts-1:0] actVal);
    if (actVal !== expVal) begin
      testErrors++;
      $display("Fail %s %s: expected %b actual %b", testName, what, expVal, actVal);
    end
  endtask

  task automatic checkIniAddr(input string what, input logic [AddrWidth-1:0] expVal,
                              input logic [AddrWidth-1:0] actVal);
    if (actVal !== expVal) begin
      valueErrors++;
      $display("Fail %s %s: expected %0d actual %0d", testName, what, expVal, actVal);
    end
  endtask

  task automatic checkData(input string what, input logic [DataWidth-1:0] expVal,
                           input logic [DataWidth-1:0] actVal);
    if (actVal !== expVal) begin
      valueErrors++;
      $display("Fail %s %s: expected %h actual %h", testName, what, expVal, actVal);
    end
  endtask

  task automatic checkLatency(input string what, input int expVal, input int actVal);
    if (actVal != expVal) begin
      valueErrors++;
      $display("Fail %s %s: expected %0d actual %0d", testName, what, expVal, actVal);
    end
  endtask

  task automatic waitDrained();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk_i);
      busy = (valid_i != '0) || (sentCnt != recvCnt);
      for (int p = 0; p < NumPorts; p++) begin
        if (todoAddr[p].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  // Drives every DUT input except reset and records each accepted request
  always @(posedge clk_i) begin
    int tgt;
    cycleCnt <= cycleCnt + 1;
    if (!rstN_i) begin
      valid_i <= '0;
      ready_i <= readyHold;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (randomMode && todoAddr[p].size() == 0 && ($urandom % 3) == 0) begin
          enqueueRequest(p, int'(AddrWidth'($urandom)));
        end
        if (!valid_i[p] || ready_o[p]) begin
          if (valid_i[p]) begin
            tgt = expectedTarget(tgtAddr_i[p]);
            expData[tgt][p].push_back(data_i[p]);
            expCycle[tgt][p].push_back(cycleCnt);
            sentCnt++;
          end
          if (todoAddr[p].size() > 0) begin
            valid_i[p]   <= 1'b1;
            tgtAddr_i[p] <= todoAddr[p].pop_front();
            data_i[p]    <= todoData[p].pop_front();
          end else begin
            valid_i[p] <= 1'b0;
          end
        end
      end
      ready_i <= randomMode ? NumPorts'($urandom) : readyHold;
    end
  end

  // Scoreboard compare on every target transfer
  always @(posedge clk_i) begin
    logic [AddrWidth-1:0] ini;
    logic [DataWidth-1:0] wantData;
    int                   acceptCycle;
    if (!rstN_i) begin
      stalled = '0;
    end else begin
      for (int t = 0; t < NumPorts; t++) begin
        // A stalled target keeps its request unchanged
        if (stalled[t]) begin
          if (!valid_o[t]) begin
            protocolErrors++;
            $display("%s: target %0d dropped valid while stalled", testName, t);
          end
          checkIniAddr("held initiator", heldIni[t], iniAddr_o[t]);
          checkData("held data", heldData[t], data_o[t]);
        end
        stalled[t]  = valid_o[t] && !ready_i[t];
        heldIni[t]  = iniAddr_o[t];
        heldData[t] = data_o[t];
        if (valid_o[t] && ready_i[t]) begin
          ini = iniAddr_o[t];
          checkIniAddr("initiator", data_o[t][DataWidth-1 -: AddrWidth], ini);
          if (expData[t][ini].size() == 0) begin
            protocolErrors++;
            $display("%s: target %0d got a request from initiator %0d that was never sent",
                     testName, t, ini);
          end else begin
            wantData    = expData[t][ini].pop_front();
            acceptCycle = expCycle[t][ini].pop_front();
            checkData("data", wantData, data_o[t]);
            if (latencyMode) begin
              checkLatency("latency", NumStages, cycleCnt - acceptCycle);
            end
          end
          recvCnt++;
        end
      end
    end
  end

  // Watchdog
  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Run timed out after %0d cycles with requests still in flight", TimeoutCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(4));

    // No valid output during reset and right after it
    repeat (ResetCycles - 1) begin
      @(negedge clk_i);
      checkValid("valid_o in reset", '0, valid_o);
    end
    @(posedge clk_i);
    rstN_i <= 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      checkValid("valid_o after reset", '0, valid_o);
    end

    // One request at a time over every pair
    testName    = "single";
    latencyMode = 1'b1;
    for (int ini = 0; ini < NumPorts; ini++) begin
      for (int tgt = 0; tgt < NumPorts; tgt++) begin
        enqueueRequest(ini, tgt);
        waitDrained();
      end
    end
    latencyMode = 1'b0;

    // Every initiator to one target
    testName = "all to one";
    for (int rep = 0; rep < 4; rep++) begin
      for (int ini = 0; ini < NumPorts; ini++) begin
        enqueueRequest(ini, HotTarget);
      end
    end
    waitDrained();

    // Stalled target with the hold checked by the scoreboard
    testName               = "backpressure";
    readyHold[StallTarget] = 1'b0;
    for (int rep = 0; rep < 2; rep++) begin
      for (int ini = 0; ini < NumPorts; ini++) begin
        enqueueRequest(ini, StallTarget);
      end
    end
    repeat (StallCycles) @(negedge clk_i);
    if (!valid_o[StallTarget]) begin
      testErrors++;
      $display("%s: no request waiting at stalled target %0d", testName, StallTarget);
    end
    // Every path to the stalled target is full and takes no more requests
    checkValid("ready_o while stalled", '0, ready_o);
    readyHold = '1;
    waitDrained();

    // Random traffic with random ready
    testName   = "random";
    randomMode = 1'b1;
    repeat (RandomCycles) @(negedge clk_i);
    randomMode = 1'b0;
    waitDrained();

    for (int t = 0; t < NumPorts; t++) begin
      for (int i = 0; i < NumPorts; i++) begin
        if (expData[t][i].size() != 0) begin
          testErrors++;
          $display("Target %0d never received %0d requests from initiator %0d",
                   t, expData[t][i].size(), i);
        end
      end
    end

    $display("Errors: %0d value mismatches, %0d protocol failures, %0d test failures",
             valueErrors, protocolErrors, testErrors);
    if (valueErrors + protocolErrors + testErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : bflyNetTb

// ==== vlog.f ====
hdl/bflyPkg.sv
hdl/bflySwitch.sv
hdl/bflyStage.sv
hdl/bflyNet.sv
tests/bflyNetTb.sv
